//--- div_pkg.sv
// Divider control package with state encoding, counter limits and condition-code layout

package div_pkg;

   ////////////////////////////////////////////////////////////////////
   // Sequencer states
   ////////////////////////////////////////////////////////////////////

   // One-hot, one bit per state
   typedef enum logic [5:0] {
      IDLE      = 6'b000001,
      RUN       = 6'b000010,
      LAST_CALC = 6'b000100,
      CHK_OVFL  = 6'b001000,
      FIX_OVFL  = 6'b010000,
      DONE      = 6'b100000
   } div_state_e;

   // Iteration counter
   localparam int unsigned DIV_CNT_W = 6;
   localparam logic [DIV_CNT_W-1:0] DIV_LAST_CNT = 6'd63;

   // Cycle counts seen from outside
   localparam int unsigned DIV_RUN_CYCLES  = 64;
   localparam int unsigned DIV_REQ_LATENCY = 68;

   ////////////////////////////////////////////////////////////////////
   // Condition codes
   ////////////////////////////////////////////////////////////////////
   localparam int unsigned CC_W       = 8;
   localparam int unsigned CC_ICC_LSB = 0;
   localparam int unsigned CC_XCC_LSB = 4;

   // Flag offsets within a nibble
   localparam int unsigned CC_N_BIT = 3;
   localparam int unsigned CC_Z_BIT = 2;
   localparam int unsigned CC_V_BIT = 1;
   localparam int unsigned CC_C_BIT = 0;

endpackage

//--- div_seq.sv
// One-hot division sequencer, iteration counter and decoded strobes

module div_seq (
   input  logic clk,
   input  logic rst_n,
   input  logic input_vld,
   input  logic wb_ack,
   input  logic div_abort,
   output logic sel_adder,
   output logic keep_d,
   output logic almostlast_cycle,
   output logic last_cycle,
   output logic wb_req
);

   import div_pkg::*;

   div_state_e           state_q;
   div_state_e           next_state;
   logic [DIV_CNT_W-1:0] cnt_q;
   logic                 cnt_last;

   ////////////////////////////////////////////////////////////////////
   // State register and next state
   ////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= IDLE;
      end else begin
         state_q <= next_state;
      end
   end

   always_comb begin
      next_state = IDLE;
      unique case (state_q)
         IDLE:      next_state = input_vld ? RUN : IDLE;
         RUN:       next_state = cnt_last ? LAST_CALC : RUN;
         // Two staging states give the overflow check time on the result
         LAST_CALC: next_state = CHK_OVFL;
         CHK_OVFL:  next_state = FIX_OVFL;
         FIX_OVFL:  next_state = DONE;
         DONE:      next_state = wb_ack ? IDLE : DONE;
         default:   next_state = IDLE;
      endcase
      // Abort wins over everything
      if (div_abort) begin
         next_state = IDLE;
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Iteration counter
   ////////////////////////////////////////////////////////////////////
   // Held at zero outside RUN
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt_q <= '0;
      end else if (state_q != RUN) begin
         cnt_q <= '0;
      end else begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   assign cnt_last = (cnt_q == DIV_LAST_CNT);

   // Strobes decoded from state
   assign sel_adder        = ((state_q == RUN) || (state_q == LAST_CALC)) && !input_vld;
   assign keep_d           = !(sel_adder || input_vld);
   // Final RUN cycle, masked by a load
   assign almostlast_cycle = (state_q == RUN) && cnt_last && !input_vld;
   assign last_cycle       = (state_q == LAST_CALC);
   assign wb_req           = (state_q == DONE);

endmodule

//--- div_qbit.sv
// Operand sign extension, quotient-bit prediction and subtract flop

module div_qbit (
   input  logic clk,
   input  logic rst_n,
   input  logic input_vld,
   input  logic almostlast_cycle,
   input  logic signed_div,
   input  logic dividend_msb,
   input  logic divisorin_31,
   input  logic xin_msb_l,
   input  logic d_msb,
   input  logic cout64,
   output logic dividend_sign,
   output logic xinmask,
   output logic keepx,
   output logic newq,
   output logic subtract,
   output logic subtract_l
);

   logic qpredict;
   logic firstlast_sub;
   logic q_next;
   logic sub_next;

   // Sign extension of dividend and divisor
   assign dividend_sign = signed_div & dividend_msb;
   assign xinmask       = signed_div & divisorin_31;

   ////////////////////////////////////////////////////////////////////
   // Quotient prediction
   ////////////////////////////////////////////////////////////////////
   // Bit 64 of the adder, late cout64 folded in last
   assign qpredict = ~(d_msb ^ subtract) ^ cout64;

   // First quotient bit comes from the dividend sign
   assign q_next = input_vld ? dividend_sign : qpredict;

   // First and last step subtract select
   // Signed case subtracts when dividend and divisor-in signs differ
   assign firstlast_sub = ~almostlast_cycle & (~signed_div | ~(dividend_msb ^ xin_msb_l));

   // Keep operation in the middle steps
   assign keepx    = ~(input_vld | almostlast_cycle);
   assign sub_next = keepx ? qpredict : (firstlast_sub ^ cout64);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         newq     <= 1'b0;
         subtract <= 1'b0;
      end else begin
         newq     <= q_next;
         subtract <= sub_next;
      end
   end

   assign subtract_l = ~subtract;

endmodule

//--- div_cin.sv
// Zero-remainder tracking and last-cycle carry-in correction

module div_cin (
   input  logic clk,
   input  logic rst_n,
   input  logic input_vld,
   input  logic almostlast_cycle,
   input  logic last_cycle,
   input  logic subtract,
   input  logic signed_div,
   input  logic x_msb,
   input  logic d_62,
   input  logic detect_zero_high,
   input  logic detect_zero_low,
   output logic cin
);

   logic detect_zero;
   logic divisor_sign;
   logic zero_rem_d;
   logic zero_rem_q;
   logic last_cin_d;
   logic last_cin_q;

   ////////////////////////////////////////////////////////////////////
   // Partial remainder zero tracking
   ////////////////////////////////////////////////////////////////////
   assign detect_zero = detect_zero_high & detect_zero_low;

   // Old flag only matters when this step is not zero
   assign zero_rem_d = ~input_vld & (~d_62 | almostlast_cycle) & (detect_zero | zero_rem_q);

   // Quotient correction for signed division
   assign divisor_sign = x_msb & signed_div;
   assign last_cin_d   = signed_div & ((divisor_sign & ~d_62) |
                                       (~divisor_sign & d_62 & ~zero_rem_d) |
                                       (divisor_sign & d_62 & zero_rem_d));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         zero_rem_q <= 1'b0;
         last_cin_q <= 1'b0;
      end else begin
         zero_rem_q <= zero_rem_d;
         last_cin_q <= last_cin_d;
      end
   end

   // Usually just subtract
   assign cin = last_cycle ? last_cin_q : subtract;

endmodule

//--- div_ccgen.sv
// Flag staging, divide overflow selects and detection, condition-code assembly

module div_ccgen (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      input_vld,
   input  logic                      signed_div,
   input  logic                      div64,
   input  logic                      dividend_msb,
   input  logic                      divisorin_31,
   input  logic                      upper32_equal,
   input  logic                      gencc_in_msb_l,
   input  logic                      gencc_in_31,
   input  logic                      low32_nonzero,
   output logic                      sel_64b,
   output logic                      sel_u32,
   output logic                      sel_pos32,
   output logic                      sel_neg32,
   output logic                      upper32_zero,
   output logic                      upper33_zero,
   output logic                      upper33_one,
   output logic [div_pkg::CC_W-1:0]  ccr_cc
);

   import div_pkg::*;

   logic upper32_equal_d1;
   logic msb_l_d1;
   logic bit31_d1;
   logic low32_nonzero_d1;
   logic inputs_neg_q;
   logic large_neg_ovfl;
   logic unsign_ovfl;
   logic pos_ovfl;
   logic neg_ovfl;
   logic div_v;

   // Datapath flags staged one cycle, sign case held from the load
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         upper32_equal_d1 <= 1'b0;
         msb_l_d1         <= 1'b0;
         bit31_d1         <= 1'b0;
         low32_nonzero_d1 <= 1'b0;
         inputs_neg_q     <= 1'b0;
      end else begin
         upper32_equal_d1 <= upper32_equal;
         msb_l_d1         <= gencc_in_msb_l;
         bit31_d1         <= gencc_in_31;
         low32_nonzero_d1 <= low32_nonzero;
         if (input_vld) begin
            inputs_neg_q <= dividend_msb & divisorin_31;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Overflow selects and detection
   ////////////////////////////////////////////////////////////////////
   // Largest negative over -1 turns positive in 32-bit mode
   assign large_neg_ovfl = inputs_neg_q & ~msb_l_d1;

   assign sel_64b   = div64;
   assign sel_u32   = ~div64 & ~signed_div;
   assign sel_pos32 = ~div64 & signed_div & (msb_l_d1 | large_neg_ovfl);
   assign sel_neg32 = ~div64 & signed_div & ~msb_l_d1 & ~large_neg_ovfl;

   assign upper32_zero = upper32_equal_d1 & msb_l_d1;
   assign upper33_zero = upper32_equal_d1 & msb_l_d1 & ~bit31_d1;
   assign upper33_one  = upper32_equal_d1 & ~msb_l_d1 & bit31_d1;

   assign unsign_ovfl = sel_u32 & ~upper32_zero;
   assign pos_ovfl    = sel_pos32 & ~upper33_zero;
   assign neg_ovfl    = sel_neg32 & ~upper33_one;
   assign div_v       = unsign_ovfl | pos_ovfl | neg_ovfl;

   // Condition codes, xcc high nibble and icc low
   always_comb begin
      ccr_cc = '0;
      ccr_cc[CC_XCC_LSB + CC_N_BIT] = ~msb_l_d1 & ~unsign_ovfl & ~pos_ovfl;
      ccr_cc[CC_XCC_LSB + CC_Z_BIT] = upper32_equal_d1 & msb_l_d1 & ~low32_nonzero_d1;
      ccr_cc[CC_XCC_LSB + CC_V_BIT] = 1'b0;
      ccr_cc[CC_XCC_LSB + CC_C_BIT] = 1'b0;
      ccr_cc[CC_ICC_LSB + CC_N_BIT] = (bit31_d1 & ~pos_ovfl) | neg_ovfl | unsign_ovfl;
      // Overflow masks zero
      ccr_cc[CC_ICC_LSB + CC_Z_BIT] = ~low32_nonzero_d1 & ~div_v;
      ccr_cc[CC_ICC_LSB + CC_V_BIT] = div_v;
      ccr_cc[CC_ICC_LSB + CC_C_BIT] = 1'b0;
   end

endmodule

//--- div_cntl.sv
// Divider control top level connecting sequencer, quotient, carry-in and cc blocks

module div_cntl (
   input  logic                     clk,
   input  logic                     rst_n,
   // Request and writeback
   input  logic                     input_vld,
   input  logic                     wb_ack,
   input  logic                     div_abort,
   // Mode
   input  logic                     signed_div,
   input  logic                     div64,
   // Datapath levels
   input  logic                     dividend_msb,
   input  logic                     divisorin_31,
   input  logic                     xin_msb_l,
   input  logic                     x_msb,
   input  logic                     d_msb,
   input  logic                     cout64,
   input  logic                     d_62,
   input  logic                     detect_zero_high,
   input  logic                     detect_zero_low,
   input  logic                     upper32_equal,
   input  logic                     gencc_in_msb_l,
   input  logic                     gencc_in_31,
   input  logic                     low32_nonzero,
   // Datapath controls
   output logic                     ld_inputs,
   output logic                     sel_adder,
   output logic                     keep_d,
   output logic                     almostlast_cycle,
   output logic                     last_cycle,
   output logic                     wb_req,
   output logic                     dividend_sign,
   output logic                     xinmask,
   output logic                     keepx,
   output logic                     newq,
   output logic                     subtract_l,
   output logic                     cin,
   // Overflow correction and cc
   output logic                     sel_64b,
   output logic                     sel_u32,
   output logic                     sel_pos32,
   output logic                     sel_neg32,
   output logic                     upper32_zero,
   output logic                     upper33_zero,
   output logic                     upper33_one,
   output logic [div_pkg::CC_W-1:0] ccr_cc
);

   logic subtract;

   // Load strobe straight from the request
   assign ld_inputs = input_vld;

   div_seq u_seq (
      .clk, .rst_n, .input_vld, .wb_ack, .div_abort,
      .sel_adder, .keep_d, .almostlast_cycle, .last_cycle, .wb_req
   );

   div_qbit u_qbit (
      .clk, .rst_n, .input_vld, .almostlast_cycle, .signed_div,
      .dividend_msb, .divisorin_31, .xin_msb_l, .d_msb, .cout64,
      .dividend_sign, .xinmask, .keepx, .newq, .subtract, .subtract_l
   );

   div_cin u_cin (
      .clk, .rst_n, .input_vld, .almostlast_cycle, .last_cycle, .subtract,
      .signed_div, .x_msb, .d_62, .detect_zero_high, .detect_zero_low, .cin
   );

   div_ccgen u_ccgen (
      .clk, .rst_n, .input_vld, .signed_div, .div64, .dividend_msb, .divisorin_31,
      .upper32_equal, .gencc_in_msb_l, .gencc_in_31, .low32_nonzero,
      .sel_64b, .sel_u32, .sel_pos32, .sel_neg32,
      .upper32_zero, .upper33_zero, .upper33_one, .ccr_cc
   );

endmodule

//--- div_cntl_chk.sv
// Bound checker for sequencer one-hot state and writeback request timing

module div_cntl_chk (
   input logic                clk,
   input logic                rst_n,
   input div_pkg::div_state_e state_q,
   input logic                last_cycle,
   input logic                wb_req,
   input logic                div_abort
);
   timeunit 1ns;
   timeprecision 1ps;

   import div_pkg::*;

   // Exactly one state bit set
   state_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(state_q))
      else $error("sequencer state is not one-hot");

   // Request only from DONE
   req_in_done: assert property (@(posedge clk) disable iff (!rst_n) wb_req |-> state_q == DONE)
      else $error("wb_req high outside DONE");

   // Three staging cycles from last_cycle to the request, unless aborted on the way
   last_to_req: assert property (@(posedge clk) disable iff (!rst_n)
      ($past(last_cycle, 3) && !$past(div_abort, 3) && !$past(div_abort, 2) && !$past(div_abort))
      |-> wb_req)
      else $error("wb_req missing three cycles after last_cycle");

endmodule

bind div_seq div_cntl_chk u_chk (
   .clk, .rst_n, .state_q, .last_cycle, .wb_req, .div_abort
);

//--- tb_clk_gen.sv
// Testbench clock and reset generator

module tb_clk_gen (
   output logic clk,
   output logic rst_n
);
   timeunit 1ns;
   timeprecision 1ps;

   // 4 ns period
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Reset held for 16 rising edges
   initial begin
      rst_n = 1'b0;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

//--- tb_div_cntl.sv
// Testbench top with transfer timing, prediction, carry-in, abort and cc table tests

module tb_div_cntl;
   timeunit 1ns;
   timeprecision 1ps;

   import div_pkg::*;

   localparam int CC_ROWS  = 6;
   localparam int WAIT_MAX = 100;

   logic clk;
   logic rst_n;
   // DUT inputs
   logic input_vld, wb_ack, div_abort, signed_div, div64;
   logic dividend_msb, divisorin_31, xin_msb_l, x_msb, d_msb, cout64, d_62;
   logic detect_zero_high, detect_zero_low;
   logic upper32_equal, gencc_in_msb_l, gencc_in_31, low32_nonzero;
   // DUT outputs
   logic ld_inputs, sel_adder, keep_d, almostlast_cycle, last_cycle, wb_req;
   logic dividend_sign, xinmask, keepx, newq, subtract_l, cin;
   logic sel_64b, sel_u32, sel_pos32, sel_neg32;
   logic upper32_zero, upper33_zero, upper33_one;
   logic [CC_W-1:0] ccr_cc;

   integer      seed;
   int          errors;
   int          tests_ok;
   int          tests_bad;
   logic        timed_out = 1'b0;
   string       cc_name [CC_ROWS];
   logic [22:0] cc_row  [CC_ROWS];

   tb_clk_gen u_clk_gen (.clk, .rst_n);

   div_cntl DUT (.*);

   // Ends the run when a wait gives up
   initial begin
      wait (timed_out);
      $display("Regression failed");
      $finish;
   end

   //////////////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////////////
   function automatic logic rand_bit();
      logic [31:0] r;
      r = $random(seed);
      return r[0];
   endfunction

   task automatic check_bit(input string name, input string what, input logic exp,
                            input logic act);
      if (act !== exp) begin
         $display("FAIL %s %s expected %0b actual %0b", name, what, exp, act);
         errors++;
      end
   endtask

   task automatic check_vec(input string name, input string what, input logic [7:0] exp,
                            input logic [7:0] act);
      if (act !== exp) begin
         $display("FAIL %s %s expected %02h actual %02h", name, what, exp, act);
         errors++;
      end
   endtask

   task automatic finish_test(input string name);
      if (errors == 0) begin
         $display("test %s: ok", name);
         tests_ok++;
      end else begin
         $display("test %s: %0d errors", name, errors);
         tests_bad++;
      end
      errors = 0;
   endtask

   // Hands the end of the run to the watcher
   task automatic report_timeout(input string what);
      $display("ERROR timeout while waiting for %s", what);
      timed_out = 1'b1;
      @(posedge clk);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Full transfer, started right after a rising edge in IDLE
   //////////////////////////////////////////////////////////////////////
   task automatic run_transfer(input string name, input logic sgn, input logic xm,
                               input logic d62, input int ack_delay);
      int   n;
      int   k;
      logic seen_req;
      logic exp_q;
      logic exp_sub;
      logic exp_lc;
      logic pb;
      logic nz;
      logic zero_prev;
      logic ds;

      // Load cycle
      input_vld        <= 1'b1;
      signed_div       <= sgn;
      x_msb            <= xm;
      detect_zero_high <= 1'b1;
      detect_zero_low  <= 1'b1;
      dividend_msb     <= rand_bit();
      divisorin_31     <= rand_bit();
      xin_msb_l        <= rand_bit();
      cout64           <= rand_bit();
      d_msb            <= rand_bit();
      @(negedge clk);
      if (wb_req !== 1'b0 || sel_adder !== 1'b0) begin
         $display("ERROR %s: block was not idle in the load cycle", name);
         errors++;
      end
      check_bit(name, "ld_inputs", 1'b1, ld_inputs);
      check_bit(name, "dividend_sign", sgn & dividend_msb, dividend_sign);
      check_bit(name, "xinmask", sgn & divisorin_31, xinmask);
      check_bit(name, "keepx", 1'b0, keepx);
      // First quotient bit and first subtract, xin_msb_l low is a negative divisor
      exp_q     = sgn & dividend_msb;
      exp_sub   = (~sgn | (dividend_msb ^ ~xin_msb_l)) ^ cout64;
      zero_prev = 1'b0;
      exp_lc    = 1'b0;
      seen_req  = 1'b0;
      n         = 0;
      while (!seen_req && n < WAIT_MAX) begin
         n++;
         @(posedge clk);
         input_vld <= 1'b0;
         d_msb     <= rand_bit();
         cout64    <= rand_bit();
         // d_62 of interest sits in the final RUN cycle
         d_62      <= (n == DIV_RUN_CYCLES) ? d62 : rand_bit();
         @(negedge clk);
         check_bit(name, "almostlast_cycle", n == DIV_RUN_CYCLES, almostlast_cycle);
         check_bit(name, "last_cycle", n == DIV_RUN_CYCLES + 1, last_cycle);
         check_bit(name, "wb_req", n == DIV_REQ_LATENCY, wb_req);
         check_bit(name, "sel_adder", n <= DIV_RUN_CYCLES + 1, sel_adder);
         check_bit(name, "keep_d", n > DIV_RUN_CYCLES + 1, keep_d);
         check_bit(name, "keepx", n != DIV_RUN_CYCLES, keepx);
         check_bit(name, "ld_inputs", 1'b0, ld_inputs);
         check_bit(name, "newq", exp_q, newq);
         check_bit(name, "subtract", exp_sub, ~subtract_l);
         if (n == DIV_RUN_CYCLES + 1) begin
            check_bit(name, "cin at last_cycle", exp_lc, cin);
         end else begin
            check_bit(name, "cin", ~subtract_l, cin);
         end
         // Expected next values from this cycle's levels
         pb        = ~(d_msb ^ ~subtract_l) ^ cout64;
         exp_q     = pb;
         exp_sub   = (n == DIV_RUN_CYCLES) ? cout64 : pb;
         nz        = (~d_62 | (n == DIV_RUN_CYCLES)) &
                     ((detect_zero_high & detect_zero_low) | zero_prev);
         ds        = x_msb & signed_div;
         exp_lc    = signed_div & ((ds & ~d_62) | (~ds & d_62 & ~nz) | (ds & d_62 & nz));
         zero_prev = nz;
         seen_req  = wb_req;
      end
      if (!seen_req) begin
         report_timeout({name, " wb_req"});
      end
      // Back-pressure, request must hold
      for (k = 0; k < ack_delay; k++) begin
         @(posedge clk);
         @(negedge clk);
         check_bit(name, "wb_req held", 1'b1, wb_req);
      end
      @(posedge clk);
      wb_ack <= 1'b1;
      @(posedge clk);
      wb_ack <= 1'b0;
      finish_test(name);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////
   initial begin
      int          n;
      int          r;
      logic [22:0] row;

      input_vld        <= 1'b0;
      wb_ack           <= 1'b0;
      div_abort        <= 1'b0;
      signed_div       <= 1'b0;
      div64            <= 1'b0;
      dividend_msb     <= 1'b0;
      divisorin_31     <= 1'b0;
      xin_msb_l        <= 1'b0;
      x_msb            <= 1'b0;
      d_msb            <= 1'b0;
      cout64           <= 1'b0;
      d_62             <= 1'b0;
      detect_zero_high <= 1'b0;
      detect_zero_low  <= 1'b0;
      upper32_equal    <= 1'b0;
      gencc_in_msb_l   <= 1'b0;
      gencc_in_31      <= 1'b0;
      low32_nonzero    <= 1'b0;
      seed = 34;
      cc_name = '{"div64_neg", "u32_ovfl", "pos_ovfl", "large_neg", "neg_ovfl", "zero_result"};
      // div64 sgn dmsb d31 | eq msb_l b31 nz | sel 64b u32 pos neg | u32z u33z u33o | xcc icc
      cc_row = '{23'b1_1_0_0_0_0_1_1_1000_000_1000_1000,
                 23'b0_0_0_0_0_1_0_1_0100_000_0000_1010,
                 23'b0_1_0_0_1_1_1_1_0010_100_0000_0010,
                 23'b0_1_1_1_1_0_1_1_0010_001_0000_0010,
                 23'b0_1_1_0_0_0_1_1_0001_000_1000_1010,
                 23'b0_1_0_1_1_1_0_0_0010_110_0100_0100};

      // Reset values, sampled before the first post-reset edge
      n = 0;
      while (rst_n !== 1'b1 && n < 40) begin
         @(negedge clk);
         n++;
      end
      if (rst_n !== 1'b1) begin
         report_timeout("reset release");
      end
      check_bit("reset", "wb_req", 1'b0, wb_req);
      check_bit("reset", "sel_adder", 1'b0, sel_adder);
      check_bit("reset", "last_cycle", 1'b0, last_cycle);
      check_bit("reset", "almostlast_cycle", 1'b0, almostlast_cycle);
      check_bit("reset", "keep_d", 1'b1, keep_d);
      check_bit("reset", "subtract_l", 1'b1, subtract_l);
      finish_test("reset");
      @(posedge clk);

      // Timing, prediction and carry-in, reload right after each ack
      run_transfer("seq_ack_delay", 1'b0, 1'b0, 1'b0, 5);
      run_transfer("reload_after_ack", 1'b1, 1'b1, 1'b0, 0);
      run_transfer("cin_sx1_d1", 1'b1, 1'b1, 1'b1, 0);
      run_transfer("cin_sx0_d1", 1'b1, 1'b0, 1'b1, 0);
      run_transfer("cin_sx0_d0", 1'b1, 1'b0, 1'b0, 0);

      // Abort in the middle of RUN
      input_vld <= 1'b1;
      @(posedge clk);
      input_vld <= 1'b0;
      repeat (20) @(posedge clk);
      div_abort <= 1'b1;
      @(posedge clk);
      div_abort <= 1'b0;
      for (n = 0; n < 80; n++) begin
         @(negedge clk);
         check_bit("abort", "wb_req", 1'b0, wb_req);
         check_bit("abort", "sel_adder", 1'b0, sel_adder);
         @(posedge clk);
      end
      finish_test("abort");
      run_transfer("after_abort", 1'b0, 1'b0, 1'b0, 1);

      // Condition-code table, load for the signs then abort
      for (r = 0; r < CC_ROWS; r++) begin
         row = cc_row[r];
         input_vld    <= 1'b1;
         div64        <= row[22];
         signed_div   <= row[21];
         dividend_msb <= row[20];
         divisorin_31 <= row[19];
         @(posedge clk);
         input_vld      <= 1'b0;
         div_abort      <= 1'b1;
         upper32_equal  <= row[18];
         gencc_in_msb_l <= row[17];
         gencc_in_31    <= row[16];
         low32_nonzero  <= row[15];
         @(posedge clk);
         div_abort <= 1'b0;
         @(negedge clk);
         check_vec(cc_name[r], "selects", {4'b0000, row[14:11]},
                   {4'b0000, sel_64b, sel_u32, sel_pos32, sel_neg32});
         check_vec(cc_name[r], "range flags", {5'b00000, row[10:8]},
                   {5'b00000, upper32_zero, upper33_zero, upper33_one});
         check_vec(cc_name[r], "ccr_cc", row[7:0], ccr_cc);
         finish_test(cc_name[r]);
         @(posedge clk);
      end

      $display("Tests: %0d ok, %0d with errors", tests_ok, tests_bad);
      if (tests_bad == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

//--- files.f
div_pkg.sv
div_seq.sv
div_qbit.sv
div_cin.sv
div_ccgen.sv
div_cntl.sv
div_cntl_chk.sv
tb_clk_gen.sv
tb_div_cntl.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -f files.f \
   --top-module tb_div_cntl -o sim_div_cntl
output=$(./obj_dir/sim_div_cntl 2>&1 || true)
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -q '^Regression passed$'; then
   exit 0
fi
exit 1
